//--- hw/tlu_params.svh
`ifndef TLU_PARAMS_SVH
`define TLU_PARAMS_SVH

// TRIGGER_CLK cycles per TLU bit period
`define TLU_DIVISOR 8

// TLU clock periods per trigger number readout, first one carries no data
`define TLU_BIT_PERIODS 32

// trigger number bits kept from the readout
`define TLU_NUMBER_WIDTH 31

// output word and trigger counter width
`define TLU_WORD_WIDTH 32

// trigger low timeout setting
`define TLU_TIMEOUT_WIDTH 8

`endif

//--- hw/tlu_pkg.sv
`include "tlu_params.svh"

package tlu_pkg;

    // output word, also timestamp and trigger counter
    typedef logic [`TLU_WORD_WIDTH-1:0] trigger_word_t;

    // serial trigger number from the TLU
    typedef logic [`TLU_NUMBER_WIDTH-1:0] tlu_number_t;

    typedef logic [`TLU_TIMEOUT_WIDTH-1:0] timeout_t; // cycles waiting for trigger low

    // 0,1 simple, 2 handshake, 3 handshake with number readout
    typedef logic [1:0] trigger_mode_t;

    typedef enum logic [2:0]
    {
        idle             = 3'b000,
        send_command     = 3'b001,
        wait_trigger_low = 3'b010,
        send_tlu_clock   = 3'b011,
        latch_data       = 3'b100,
        wait_ack         = 3'b101
    } tlu_state_t;

endpackage

//--- hw/tlu_timebase.sv
`timescale 1ns/100ps
`include "tlu_params.svh"

module tlu_timebase import tlu_pkg::*;
(
    input  logic          TRIGGER_CLK,
    input  logic          RESET,
    input  logic          tlu_reset_flag,
    input  logic          accept,
    input  logic          counter_set,
    input  trigger_word_t counter_set_value,
    output trigger_word_t timestamp,
    output trigger_word_t trigger_count
);

    // free running, TLU reset restarts it
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || tlu_reset_flag)
            timestamp <= '0;
        else
            timestamp <= timestamp + `TLU_WORD_WIDTH'(1);
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trigger_count <= '0;
        else if (counter_set) // preset wins over a trigger in the same cycle
            trigger_count <= counter_set_value;
        else if (accept)
            trigger_count <= trigger_count + `TLU_WORD_WIDTH'(1);
    end

    // any counter change comes from a preset or one accepted trigger
    assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        (trigger_count != $past(trigger_count)) |->
            (($past(counter_set) && trigger_count == $past(counter_set_value)) ||
             ($past(accept) && !$past(counter_set) &&
              trigger_count == trigger_word_t'($past(trigger_count) + 1'b1))))
        else $error("trigger counter changed without preset or accept");

endmodule

//--- hw/tlu_number_capture.sv
`timescale 1ns/100ps
`include "tlu_params.svh"

module tlu_number_capture import tlu_pkg::*;
(
    input  logic        TRIGGER_CLK,
    input  logic        RESET,
    input  logic        trigger,
    input  logic        period_start,
    input  logic        sample_strobe,
    input  logic        msb_first,
    output tlu_number_t tlu_number
);

    localparam int strobe_w = $clog2(`TLU_BIT_PERIODS);

    logic                armed;      // inside a readout sequence
    logic [strobe_w-1:0] strobe_cnt; // strobes seen since period_start
    logic                data_bit;   // strobe of a period that carries a bit
    tlu_number_t         shift_q;

    assign data_bit = sample_strobe && (strobe_cnt != '0);

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            armed      <= 1'b0;
            strobe_cnt <= '0;
        end
        else if (period_start)
        begin
            armed      <= 1'b1;
            strobe_cnt <= '0;
        end
        else if (sample_strobe)
        begin
            strobe_cnt <= strobe_cnt + 1'b1;
            if (strobe_cnt == strobe_w'(`TLU_BIT_PERIODS - 1))
                armed <= 1'b0; // last period sampled
        end
    end

    // first period is only the TLU start clock, its sample is dropped
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (period_start)
            shift_q <= '0;
        else if (data_bit)
        begin
            if (msb_first)
                shift_q <= {shift_q[`TLU_NUMBER_WIDTH-2:0], trigger}; // first bit ends at the top
            else
                shift_q <= {trigger, shift_q[`TLU_NUMBER_WIDTH-1:1]}; // first bit ends at bit 0
        end
    end

    assign tlu_number = shift_q;

    // the FSM must open a sequence before it strobes data
    assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        sample_strobe |-> armed)
        else $error("sample strobe outside a readout sequence");

endmodule

//--- hw/tlu_handshake_fsm.sv
`timescale 1ns/100ps
`include "tlu_params.svh"

module tlu_handshake_fsm import tlu_pkg::*;
(
    input  logic          TRIGGER_CLK,
    input  logic          RESET,
    input  logic          trigger,
    input  logic          trigger_enable,
    input  logic          trigger_veto,
    input  trigger_mode_t trigger_mode,
    input  timeout_t      low_time_out,
    input  logic          trigger_acknowledge,
    input  logic          fifo_acknowledge,
    output logic          accept,
    output logic          period_start,
    output logic          sample_strobe,
    output logic          latch_number,
    output logic          trigger_data_write,
    output logic          trigger_accepted_flag,
    output logic          fifo_preempt_req,
    output logic          tlu_busy,
    output logic          tlu_clock,
    output logic          low_timeout_error
);

    localparam int period_w = $clog2(`TLU_DIVISOR);
    localparam int bit_w    = $clog2(`TLU_BIT_PERIODS);

    tlu_state_t          state;
    tlu_state_t          next;
    logic                trigger_ff;
    logic                trigger_edge;
    logic                accept_ok;
    timeout_t            timeout_cnt;
    logic                timeout_hit;
    logic [period_w-1:0] period_cnt;
    logic [period_w-1:0] period_nxt;
    logic [bit_w-1:0]    bit_cnt;
    logic                period_last;
    logic                clock_done;
    logic                trigger_acked;
    logic                fifo_acked;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trigger_ff <= 1'b0;
        else
            trigger_ff <= trigger;
    end

    assign trigger_edge = trigger && !trigger_ff;

    // readout side must be quiet before a new trigger
    assign accept_ok = trigger_edge && trigger_enable && !trigger_veto &&
                       !trigger_acknowledge && !fifo_acknowledge;

    // zero disables the timeout
    assign timeout_hit = (low_time_out != '0) &&
                         (timeout_cnt == timeout_t'(low_time_out - 1'b1));

    assign period_last = (period_cnt == period_w'(`TLU_DIVISOR - 1));
    assign clock_done  = period_last && (bit_cnt == bit_w'(`TLU_BIT_PERIODS - 1));
    assign period_nxt  = (state == send_tlu_clock && !period_last) ? period_cnt + 1'b1 : '0;

    always_comb
    begin
        next = state;
        case (state)
            idle:
                if (accept_ok)
                    next = trigger_mode[1] ? wait_trigger_low : send_command; // mode 1 runs as 0
            send_command:
                next = latch_data;
            wait_trigger_low:
                if (!trigger || timeout_hit)
                    next = (trigger_mode == 2'b11) ? send_tlu_clock : latch_data;
            send_tlu_clock:
                if (clock_done)
                    next = latch_data;
            latch_data:
                next = wait_ack;
            wait_ack:
                if (trigger_acked && fifo_acked)
                    next = idle;
            default:
                next = idle;
        endcase
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            state <= idle;
        else
            state <= next;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            timeout_cnt <= '0;
            period_cnt  <= '0;
            bit_cnt     <= '0;
        end
        else
        begin
            timeout_cnt <= (state == wait_trigger_low) ? timeout_cnt + 1'b1 : '0;
            period_cnt  <= period_nxt;
            if (state != send_tlu_clock)
                bit_cnt <= '0;
            else if (period_last)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // acks stick until the FSM is back in idle
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || state == idle)
        begin
            trigger_acked <= 1'b0;
            fifo_acked    <= 1'b0;
        end
        else
        begin
            if (trigger_acknowledge)
                trigger_acked <= 1'b1;
            if (fifo_acknowledge)
                fifo_acked <= 1'b1;
        end
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            accept                <= 1'b0;
            trigger_accepted_flag <= 1'b0;
            tlu_busy              <= 1'b0;
            fifo_preempt_req      <= 1'b0;
            trigger_data_write    <= 1'b0;
            low_timeout_error     <= 1'b0;
            tlu_clock             <= 1'b0;
        end
        else
        begin
            accept                <= (state == idle) && (next != idle);
            trigger_accepted_flag <= accept;
            tlu_busy              <= (state != idle);
            fifo_preempt_req      <= (state != idle);
            trigger_data_write    <= (state == latch_data);
            low_timeout_error     <= (state == wait_trigger_low) && trigger && timeout_hit;
            // high for the first half of each bit period
            tlu_clock <= (next == send_tlu_clock) && (period_nxt < period_w'(`TLU_DIVISOR / 2));
        end
    end

    assign sample_strobe = (state == send_tlu_clock) && period_last; // end of each period
    assign period_start  = (state == send_tlu_clock) && (period_cnt == '0) && (bit_cnt == '0);
    assign latch_number  = (state == latch_data);

    // a word is only written inside an open request
    assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        trigger_data_write |-> fifo_preempt_req)
        else $error("trigger word written without preempt request");

endmodule

//--- hw/trigger_word_latch.sv
`timescale 1ns/100ps
`include "tlu_params.svh"

module trigger_word_latch import tlu_pkg::*;
(
    input  logic          TRIGGER_CLK,
    input  logic          RESET,
    input  logic          accept,
    input  logic          latch_number,
    input  trigger_word_t timestamp,
    input  trigger_word_t trigger_count,
    input  tlu_number_t   tlu_number,
    input  trigger_mode_t trigger_mode,
    input  logic          write_timestamp,
    output trigger_word_t trigger_data
);

    trigger_word_t timestamp_q;
    trigger_word_t count_q;
    tlu_number_t   number_q;
    logic          ts_sel_q;  // word carries the timestamp
    logic          num_sel_q; // word carries the TLU number

    // word source frozen for the whole handshake
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            ts_sel_q  <= 1'b0;
            num_sel_q <= 1'b0;
        end
        else if (accept)
        begin
            ts_sel_q  <= write_timestamp;
            num_sel_q <= (trigger_mode == 2'b11);
        end
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (accept)
        begin
            timestamp_q <= timestamp;
            count_q     <= trigger_count; // value before this trigger's increment
        end
        if (latch_number)
            number_q <= tlu_number;
    end

    // bit 31 marks a trigger word
    always_comb
    begin
        if (ts_sel_q)
            trigger_data = {1'b1, timestamp_q[`TLU_NUMBER_WIDTH-1:0]};
        else if (num_sel_q)
            trigger_data = {1'b1, number_q};
        else
            trigger_data = {1'b1, count_q[`TLU_NUMBER_WIDTH-1:0]};
    end

endmodule

//--- hw/tlu_controller.sv
`timescale 1ns/100ps
`include "tlu_params.svh"

module tlu_controller import tlu_pkg::*;
(
    input  logic          TRIGGER_CLK,
    input  logic          RESET,
    input  logic          trigger,
    input  logic          trigger_enable,
    input  logic          trigger_veto,
    input  trigger_mode_t trigger_mode,
    input  logic          trigger_counter_set,
    input  trigger_word_t trigger_counter_set_value,
    input  logic          write_timestamp,
    input  logic          tlu_reset_flag,
    input  logic          tlu_number_msb_first,
    input  timeout_t      tlu_low_time_out,
    input  logic          trigger_acknowledge,
    input  logic          fifo_acknowledge,
    output trigger_word_t trigger_data,
    output logic          trigger_data_write,
    output logic          trigger_accepted_flag,
    output logic          fifo_preempt_req,
    output logic          tlu_busy,
    output logic          tlu_clock,
    output logic          low_timeout_error,
    output trigger_word_t timestamp
);

    logic          accept;        // one cycle per accepted trigger
    logic          period_start;
    logic          sample_strobe;
    logic          latch_number;
    tlu_number_t   tlu_number;
    trigger_word_t trigger_count;

    tlu_handshake_fsm u_fsm
    (
        .TRIGGER_CLK           (TRIGGER_CLK),
        .RESET                 (RESET),
        .trigger               (trigger),
        .trigger_enable        (trigger_enable),
        .trigger_veto          (trigger_veto),
        .trigger_mode          (trigger_mode),
        .low_time_out          (tlu_low_time_out),
        .trigger_acknowledge   (trigger_acknowledge),
        .fifo_acknowledge      (fifo_acknowledge),
        .accept                (accept),
        .period_start          (period_start),
        .sample_strobe         (sample_strobe),
        .latch_number          (latch_number),
        .trigger_data_write    (trigger_data_write),
        .trigger_accepted_flag (trigger_accepted_flag),
        .fifo_preempt_req      (fifo_preempt_req),
        .tlu_busy              (tlu_busy),
        .tlu_clock             (tlu_clock),
        .low_timeout_error     (low_timeout_error)
    );

    tlu_timebase u_timebase
    (
        .TRIGGER_CLK       (TRIGGER_CLK),
        .RESET             (RESET),
        .tlu_reset_flag    (tlu_reset_flag),
        .accept            (accept),
        .counter_set       (trigger_counter_set),
        .counter_set_value (trigger_counter_set_value),
        .timestamp         (timestamp),
        .trigger_count     (trigger_count)
    );

    // trigger line doubles as the serial data line in mode 3
    tlu_number_capture u_capture
    (
        .TRIGGER_CLK   (TRIGGER_CLK),
        .RESET         (RESET),
        .trigger       (trigger),
        .period_start  (period_start),
        .sample_strobe (sample_strobe),
        .msb_first     (tlu_number_msb_first),
        .tlu_number    (tlu_number)
    );

    trigger_word_latch u_latch
    (
        .TRIGGER_CLK     (TRIGGER_CLK),
        .RESET           (RESET),
        .accept          (accept),
        .latch_number    (latch_number),
        .timestamp       (timestamp),
        .trigger_count   (trigger_count),
        .tlu_number      (tlu_number),
        .trigger_mode    (trigger_mode),
        .write_timestamp (write_timestamp),
        .trigger_data    (trigger_data)
    );

endmodule

//--- bench/tb_tlu_controller.sv
`timescale 1ns/100ps
`include "tlu_params.svh"

module tb_tlu_controller import tlu_pkg::*;
();

    // rough cycle budget per test, trigger count times cycles per trigger
    localparam int test_cycles = 10 + 4 * 40 + 3 * 40 + 4 * 330 + 2 * 90 + 150;
    localparam int clk_period  = 20;

    logic          TRIGGER_CLK = 1'b0;
    logic          RESET;
    logic          trigger;
    logic          trigger_line;    // plain trigger level from the tests
    logic          serial_mode;     // trigger line carries the TLU serial number
    logic          tlu_serial = 1'b0;
    logic          trigger_enable;
    logic          trigger_veto;
    trigger_mode_t trigger_mode;
    logic          trigger_counter_set;
    trigger_word_t trigger_counter_set_value;
    logic          write_timestamp;
    logic          tlu_reset_flag;
    logic          tlu_number_msb_first;
    timeout_t      tlu_low_time_out;
    logic          trigger_acknowledge;
    logic          fifo_acknowledge;
    trigger_word_t trigger_data;
    logic          trigger_data_write;
    logic          trigger_accepted_flag;
    logic          fifo_preempt_req;
    logic          tlu_busy;
    logic          tlu_clock;
    logic          low_timeout_error;
    trigger_word_t timestamp;

    int            write_count = 0;
    int            flag_count = 0;
    int            error_count = 0;
    int            clock_rises = 0;
    int            serial_base = 0;
    int            period_idx;
    logic          clock_now = 1'b0;
    logic          clock_prev = 1'b0;
    trigger_word_t last_word;
    trigger_word_t flag_timestamp;
    trigger_word_t expected_count = '0; // counter value the next trigger should carry
    tlu_number_t   serial_number;

    assign trigger = serial_mode ? tlu_serial : trigger_line;

    always #10 TRIGGER_CLK = ~TRIGGER_CLK; // 20 ns period

    tlu_controller dut
    (
        .TRIGGER_CLK               (TRIGGER_CLK),
        .RESET                     (RESET),
        .trigger                   (trigger),
        .trigger_enable            (trigger_enable),
        .trigger_veto              (trigger_veto),
        .trigger_mode              (trigger_mode),
        .trigger_counter_set       (trigger_counter_set),
        .trigger_counter_set_value (trigger_counter_set_value),
        .write_timestamp           (write_timestamp),
        .tlu_reset_flag            (tlu_reset_flag),
        .tlu_number_msb_first      (tlu_number_msb_first),
        .tlu_low_time_out          (tlu_low_time_out),
        .trigger_acknowledge       (trigger_acknowledge),
        .fifo_acknowledge          (fifo_acknowledge),
        .trigger_data              (trigger_data),
        .trigger_data_write        (trigger_data_write),
        .trigger_accepted_flag     (trigger_accepted_flag),
        .fifo_preempt_req          (fifo_preempt_req),
        .tlu_busy                  (tlu_busy),
        .tlu_clock                 (tlu_clock),
        .low_timeout_error         (low_timeout_error),
        .timestamp                 (timestamp)
    );

    // outputs sampled mid cycle, counters read by the tests on posedge
    always @(negedge TRIGGER_CLK)
    begin
        clock_now <= tlu_clock;
        if (trigger_data_write)
        begin
            write_count <= write_count + 1;
            last_word   <= trigger_data;
        end
        if (trigger_accepted_flag)
        begin
            flag_count     <= flag_count + 1;
            flag_timestamp <= timestamp;
        end
        if (low_timeout_error)
            error_count <= error_count + 1;
    end

    // serial bit k-1 goes out in period k, the sample of period 0 carries nothing
    function automatic logic serial_bit(input tlu_number_t number, input logic msb_first,
                                        input int idx);
        if (msb_first)
            return number[`TLU_NUMBER_WIDTH-1-idx];
        else
            return number[idx];
    endfunction

    // TLU model, next bit after each tlu_clock rise
    always @(posedge TRIGGER_CLK)
    begin
        clock_prev <= clock_now;
        if (clock_now && !clock_prev)
        begin
            period_idx = clock_rises - serial_base;
            clock_rises <= clock_rises + 1;
            if (serial_mode && period_idx >= 1 && period_idx < `TLU_BIT_PERIODS)
                tlu_serial <= serial_bit(serial_number, tlu_number_msb_first, period_idx - 1);
            else
                tlu_serial <= 1'b0;
        end
        else if (!serial_mode)
            tlu_serial <= 1'b0;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input trigger_word_t got,
                              input trigger_word_t expected);
        if (got !== expected)
        begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
            abort_run();
        end
    endtask

    task automatic wait_accepts(input int target);
        int cycles = 0;
        while (flag_count < target)
        begin
            if (cycles == 20)
            begin
                $display("ERROR: trigger was not accepted within 20 cycles");
                abort_run();
            end
            cycles++;
            @(posedge TRIGGER_CLK);
        end
    endtask

    task automatic wait_writes(input int target);
        int cycles = 0;
        while (write_count < target)
        begin
            if (cycles == 400)
            begin
                $display("ERROR: no trigger word written within 400 cycles");
                abort_run();
            end
            cycles++;
            @(posedge TRIGGER_CLK);
        end
    endtask

    task automatic wait_request_low();
        int cycles = 0;
        @(negedge TRIGGER_CLK);
        while (fifo_preempt_req)
        begin
            if (cycles == 50)
            begin
                $display("ERROR: fifo_preempt_req stayed high after both acknowledges");
                abort_run();
            end
            cycles++;
            @(negedge TRIGGER_CLK);
        end
    endtask

    task automatic respond_acks();
        repeat ($urandom_range(1, 6)) @(posedge TRIGGER_CLK);
        trigger_acknowledge <= 1'b1;
        repeat ($urandom_range(0, 4)) @(posedge TRIGGER_CLK);
        fifo_acknowledge <= 1'b1;
        wait_request_low();
        @(posedge TRIGGER_CLK);
        trigger_acknowledge <= 1'b0;
        fifo_acknowledge    <= 1'b0;
    endtask

    task automatic pulse_trigger(input int high_cycles);
        @(posedge TRIGGER_CLK);
        trigger_line <= 1'b1;
        repeat (high_cycles) @(posedge TRIGGER_CLK);
        trigger_line <= 1'b0;
        repeat (4) @(posedge TRIGGER_CLK);
    endtask

    // one accepted trigger up to its written word, acks optional
    task automatic run_trigger(input logic serial, input int high_cycles, input logic ack,
                               output trigger_word_t word, output trigger_word_t count_word);
        int flags0 = flag_count;
        int writes0 = write_count;
        count_word = {1'b1, expected_count[`TLU_NUMBER_WIDTH-1:0]};
        expected_count = expected_count + 1'b1;
        @(posedge TRIGGER_CLK);
        trigger_line <= 1'b1;
        wait_accepts(flags0 + 1);
        if (serial)
        begin
            trigger_line <= 1'b0; // trigger low starts the TLU clock
            serial_mode  <= 1'b1;
        end
        else
        begin
            repeat (high_cycles) @(posedge TRIGGER_CLK);
            trigger_line <= 1'b0;
        end
        wait_writes(writes0 + 1);
        serial_mode <= 1'b0;
        word = last_word;
        if (ack)
            respond_acks();
        check_word("write pulses", trigger_word_t'(write_count - writes0), 1);
        check_word("accepted flags", trigger_word_t'(flag_count - flags0), 1);
    endtask

    task automatic test_counting();
        trigger_word_t preset;
        trigger_word_t word;
        trigger_word_t count_word;
        trigger_word_t expected;
        preset = $urandom();
        @(posedge TRIGGER_CLK);
        trigger_mode              <= 2'b00;
        trigger_counter_set       <= 1'b1;
        trigger_counter_set_value <= preset;
        @(posedge TRIGGER_CLK);
        trigger_counter_set <= 1'b0;
        expected_count = preset;
        for (int n = 1; n <= 4; n++)
        begin
            run_trigger(1'b0, 1, 1'b1, word, count_word);
            expected = preset + trigger_word_t'(n - 1);
            expected[31] = 1'b1;
            check_word("trigger_data", word, expected);
        end
    endtask

    task automatic test_timestamp();
        trigger_word_t word;
        trigger_word_t count_word;
        trigger_word_t expected;
        @(posedge TRIGGER_CLK);
        tlu_reset_flag <= 1'b1;
        @(posedge TRIGGER_CLK);
        tlu_reset_flag <= 1'b0;
        @(negedge TRIGGER_CLK);
        check_word("timestamp", timestamp, '0); // TLU reset restarts the timestamp
        @(negedge TRIGGER_CLK);
        check_word("timestamp", timestamp, 1);
        @(posedge TRIGGER_CLK);
        write_timestamp <= 1'b1;
        repeat (3)
        begin
            run_trigger(1'b0, 1, 1'b1, word, count_word);
            expected = flag_timestamp - 1'b1; // captured one cycle before the flag
            expected[31] = 1'b1;
            check_word("trigger_data", word, expected);
        end
        @(posedge TRIGGER_CLK);
        write_timestamp <= 1'b0;
    endtask

    task automatic test_readout();
        trigger_word_t word;
        trigger_word_t count_word;
        @(posedge TRIGGER_CLK);
        trigger_mode     <= 2'b11;
        tlu_low_time_out <= '0;
        for (int i = 0; i < 4; i++)
        begin
            @(posedge TRIGGER_CLK);
            tlu_number_msb_first <= i[0];
            serial_number = tlu_number_t'($urandom());
            serial_base = clock_rises;
            run_trigger(1'b1, 1, 1'b1, word, count_word);
            check_word("trigger_data", word, {1'b1, serial_number});
            check_word("tlu_clock rises", trigger_word_t'(clock_rises - serial_base),
                       `TLU_BIT_PERIODS);
        end
    endtask

    task automatic test_timeout();
        trigger_word_t word;
        trigger_word_t count_word;
        int errors0;
        @(posedge TRIGGER_CLK);
        trigger_mode     <= 2'b10;
        tlu_low_time_out <= 8'd20;
        errors0 = error_count;
        run_trigger(1'b0, 40, 1'b1, word, count_word); // held high well past the timeout
        check_word("trigger_data", word, count_word);
        check_word("low_timeout_error pulses", trigger_word_t'(error_count - errors0), 1);
        @(posedge TRIGGER_CLK);
        tlu_low_time_out <= '0;
        errors0 = error_count;
        run_trigger(1'b0, 10, 1'b1, word, count_word);
        check_word("trigger_data", word, count_word);
        check_word("low_timeout_error pulses", trigger_word_t'(error_count - errors0), 0);
    endtask

    task automatic test_handshake();
        trigger_word_t word;
        trigger_word_t count_word;
        int flags0;
        int writes0;
        @(posedge TRIGGER_CLK);
        trigger_mode <= 2'b00;
        flags0  = flag_count;
        writes0 = write_count;
        run_trigger(1'b0, 1, 1'b0, word, count_word);
        trigger_acknowledge <= 1'b1; // fifo side holds off
        repeat (3)
        begin
            pulse_trigger(2);
            @(negedge TRIGGER_CLK);
            check_flag("fifo_preempt_req", fifo_preempt_req, 1'b1);
            check_flag("tlu_busy", tlu_busy, 1'b1);
        end
        @(posedge TRIGGER_CLK);
        check_word("write pulses", trigger_word_t'(write_count - writes0), 1);
        check_word("accepted flags", trigger_word_t'(flag_count - flags0), 1);
        fifo_acknowledge <= 1'b1;
        wait_request_low();
        @(posedge TRIGGER_CLK);
        trigger_acknowledge <= 1'b0;
        fifo_acknowledge    <= 1'b0;
        trigger_veto        <= 1'b1;
        pulse_trigger(2);
        trigger_veto   <= 1'b0;
        trigger_enable <= 1'b0;
        pulse_trigger(2);
        trigger_enable <= 1'b1;
        check_word("accepted flags", trigger_word_t'(flag_count - flags0), 1);
        check_word("write pulses", trigger_word_t'(write_count - writes0), 1);
        run_trigger(1'b0, 1, 1'b1, word, count_word); // gates open again
    endtask

    initial
    begin
        void'($urandom(32'h0c41_32e0));
        RESET                     = 1'b1;
        trigger_line              = 1'b0;
        serial_mode               = 1'b0;
        trigger_enable            = 1'b1;
        trigger_veto              = 1'b0;
        trigger_mode              = 2'b00;
        trigger_counter_set       = 1'b0;
        trigger_counter_set_value = '0;
        write_timestamp           = 1'b0;
        tlu_reset_flag            = 1'b0;
        tlu_number_msb_first      = 1'b0;
        tlu_low_time_out          = '0;
        trigger_acknowledge       = 1'b0;
        fifo_acknowledge          = 1'b0;
        repeat (10) @(posedge TRIGGER_CLK);
        RESET <= 1'b0;
        @(negedge TRIGGER_CLK);
        check_flag("trigger_data_write", trigger_data_write, 1'b0);
        check_flag("trigger_accepted_flag", trigger_accepted_flag, 1'b0);
        check_flag("fifo_preempt_req", fifo_preempt_req, 1'b0);
        check_flag("tlu_busy", tlu_busy, 1'b0);
        check_flag("tlu_clock", tlu_clock, 1'b0);
        check_flag("low_timeout_error", low_timeout_error, 1'b0);
        test_counting();
        test_timestamp();
        test_readout();
        test_timeout();
        test_handshake();
        $display("No errors");
        $finish;
    end

    // twice the summed test budget
    initial
    begin
        #(2 * test_cycles * clk_period);
        $display("ERROR: watchdog expired before the tests completed");
        abort_run();
    end

endmodule

//--- compile.f
+incdir+hw
hw/tlu_pkg.sv
hw/tlu_timebase.sv
hw/tlu_number_capture.sv
hw/tlu_handshake_fsm.sv
hw/trigger_word_latch.sv
hw/tlu_controller.sv
bench/tb_tlu_controller.sv
